// File: rtl/ilk_tx_settings.svh
// ====================================================================
// build time settings for the lane transmit path: lane count,
// FIFO depth and per lane scrambler seeding
// ====================================================================

`ifndef ILK_TX_SETTINGS_SVH
`define ILK_TX_SETTINGS_SVH

// number of lanes in the bundle
// the striper and the bus types assume four words per beat
`define ILK_LANES 4

// depth of the beat FIFO in the striper and of each lane word FIFO
`define ILK_FIFO_DEPTH 4

// scrambler state loaded into lane 0 at reset
// must never be all zeros or the LFSR stalls
`define ILK_SCRAMBLER_SEED 58'h3c5_a96e_1f07_d2b4

// lane i starts from seed + i * step so that lanes carry
// uncorrelated keystreams even when they transmit the same words
`define ILK_SCRAMBLER_STEP 58'h0e5_3b71

`endif

// File: rtl/ilk_word_pkg.sv
// ====================================================================
// protocol word formats: lane words, control word fields,
// sync headers and framed lane blocks
// ====================================================================

package ilk_word_pkg;

	// one word on its way to a lane, bit 64 set means control word
	typedef struct packed {
		logic        ctrl;
		logic [63:0] data;
	} lane_word_t;

	typedef enum logic [1:0] {
		CTRL_IDLE  = 2'd0, // filler when a lane has nothing to carry
		CTRL_BURST = 2'd1, // opens a burst on a channel
		CTRL_EOP   = 2'd2  // closes a packet
	} ctrl_type_t;

	// control payload, type field sits at the top of the word
	typedef struct packed {
		ctrl_type_t  kind;
		logic [7:0]  chan;
		logic [2:0]  eop_bytes; // bytes valid in the last data word, 0 means all 8
		logic [50:0] pad;
	} ctrl_word_t;

	typedef enum logic [1:0] {
		SYNC_DATA = 2'b01,
		SYNC_CTRL = 2'b10
	} sync_hdr_t;

	// 66 bit block as it leaves a lane, header is never scrambled
	typedef struct packed {
		sync_hdr_t   sync;
		logic [63:0] data;
	} lane_block_t;

	// builds a complete control lane word with zero padding
	function automatic lane_word_t ctrl_lane_word(ctrl_type_t kind, logic [7:0] chan,
		logic [2:0] eop_bytes);
		ctrl_word_t cw;
		cw = '{kind: kind, chan: chan, eop_bytes: eop_bytes, pad: '0};
		return '{ctrl: 1'b1, data: cw};
	endfunction

endpackage

// File: rtl/ilk_bus_pkg.sv
// ====================================================================
// transfer bundles: the input beat, the row handed to the lanes
// and the framed row at the output
// ====================================================================

`include "ilk_tx_settings.svh"

package ilk_bus_pkg;

	// one beat from the packet source
	// words[0] is the most significant word and is sent first
	typedef struct packed {
		logic [0:3][63:0] words;
		logic [2:0]       count;     // valid words, 1 to 4, taken from words[0] upward
		logic [7:0]       chan;
		logic             sop;
		logic             eop;
		logic [2:0]       eop_bytes; // bytes valid in the last word when eop is set
	} tx_beat_t;

	// row[k] goes to lane k
	typedef ilk_word_pkg::lane_word_t [`ILK_LANES-1:0] lane_row_t;

	// one framed block per lane, same lane order as lane_row_t
	typedef ilk_word_pkg::lane_block_t [`ILK_LANES-1:0] out_row_t;

endpackage

// File: rtl/ilk_fifo.sv
// ====================================================================
// synchronous FIFO with a type parameter for the payload
// ====================================================================

`timescale 1ns/1ps

module ilk_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t wdata,
	input  logic     pop,
	output payload_t rdata,
	output logic     empty,
	output logic     full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t       mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [AW:0]    count; // one bit wider so that DEPTH itself fits
	logic           do_push;
	logic           do_pop;

	assign do_push = push && !full; // a push into a full FIFO is dropped
	assign do_pop  = pop && !empty;
	assign empty   = (count == '0);
	assign full    = (count == (AW+1)'(DEPTH));
	assign rdata   = mem[rd_ptr]; // head entry, only meaningful while not empty

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// pointers wrap explicitly so DEPTH need not be a power of two
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

endmodule

// File: rtl/ilk_tx_striper.sv
// ====================================================================
// transmit striper: four phase input handshake, beat buffering and
// row generation with burst/eop control insertion and idle fill
// ====================================================================

`timescale 1ns/1ps
`include "ilk_tx_settings.svh"

module ilk_tx_striper (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_req,
	input  ilk_bus_pkg::tx_beat_t  in_beat,
	output logic                   in_ack,
	input  logic [`ILK_LANES-1:0]  lane_full,
	output ilk_bus_pkg::lane_row_t row,
	output logic                   row_push
);

	typedef enum logic {
		HS_IDLE, // waiting for a new request
		HS_ACK   // beat captured, holding ack until the source drops req
	} hs_state_t;

	typedef enum logic [1:0] {
		PH_SOP,  // burst control row, skipped when the head beat has no sop
		PH_DATA, // the data words themselves
		PH_EOP   // eop control row
	} phase_t;

	hs_state_t             hs_state;
	phase_t                phase;
	phase_t                cur_phase; // phase after skipping an absent sop row
	ilk_bus_pkg::tx_beat_t head;
	logic                  beat_push;
	logic                  beat_pop;
	logic                  beat_empty;
	logic                  beat_full;

	// the beat is written in the cycle req is seen, ack follows one cycle later
	assign beat_push = (hs_state == HS_IDLE) && in_req && !beat_full;
	assign in_ack    = (hs_state == HS_ACK);

	always_ff @(posedge clk)
	begin
		if (rst)
			hs_state <= HS_IDLE;
		else if (beat_push)
			hs_state <= HS_ACK;
		else if (hs_state == HS_ACK && !in_req)
			hs_state <= HS_IDLE; // source has released, ack drops next
	end

	ilk_fifo #(
		.payload_t (ilk_bus_pkg::tx_beat_t),
		.DEPTH     (`ILK_FIFO_DEPTH)
	) i_beat_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (beat_push),
		.wdata (in_beat),
		.pop   (beat_pop),
		.rdata (head),
		.empty (beat_empty),
		.full  (beat_full)
	);

	assign cur_phase = (phase == PH_SOP && !head.sop) ? PH_DATA : phase;

	// all lanes must have room, so every lane takes the same row in the same cycle
	assign row_push = !beat_empty && !(|lane_full);

	// the head beat leaves after its last row, data row or eop row
	assign beat_pop = row_push && (cur_phase == PH_EOP || (cur_phase == PH_DATA && !head.eop));

	always_ff @(posedge clk)
	begin
		if (rst)
			phase <= PH_SOP;
		else if (row_push)
		begin
			case (cur_phase)
				PH_SOP:  phase <= PH_DATA;
				PH_DATA: phase <= head.eop ? PH_EOP : PH_SOP;
				default: phase <= PH_SOP; // eop row done, next beat starts over
			endcase
		end
	end

	always_comb
	begin
		// every slot starts as idle and is overwritten where there is content
		for (int k = 0; k < `ILK_LANES; k++)
			row[k] = ilk_word_pkg::ctrl_lane_word(ilk_word_pkg::CTRL_IDLE, 8'd0, 3'd0);
		case (cur_phase)
			PH_SOP:
				row[0] = ilk_word_pkg::ctrl_lane_word(ilk_word_pkg::CTRL_BURST, head.chan, 3'd0);
			PH_EOP:
				row[0] = ilk_word_pkg::ctrl_lane_word(ilk_word_pkg::CTRL_EOP, head.chan,
					head.eop_bytes);
			default:
				for (int k = 0; k < `ILK_LANES; k++)
					if (k < int'(head.count))
						row[k] = '{ctrl: 1'b0, data: head.words[k]}; // word k to lane k
		endcase
	end

endmodule

// File: rtl/ilk_lane_tx.sv
// ====================================================================
// single lane transmitter: word FIFO, x^58 + x^39 + 1 scrambler
// and 66 bit block framing with a two bit sync header
// ====================================================================

`timescale 1ns/1ps
`include "ilk_tx_settings.svh"

module ilk_lane_tx #(
	parameter logic [57:0] SEED = `ILK_SCRAMBLER_SEED
) (
	input  logic                      clk,
	input  logic                      rst,
	input  ilk_word_pkg::lane_word_t  word,
	input  logic                      word_push,
	output logic                      full,
	output ilk_word_pkg::lane_block_t blk,
	output logic                      blk_valid,
	input  logic                      blk_take
);

	ilk_word_pkg::lane_word_t head;
	logic                     empty;
	logic                     pop;
	logic [57:0]              lfsr;      // scrambler state, survives across words
	logic [57:0]              lfsr_next; // state after 64 steps
	logic [63:0]              scr_data;

	ilk_fifo #(
		.payload_t (ilk_word_pkg::lane_word_t),
		.DEPTH     (`ILK_FIFO_DEPTH)
	) i_word_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (word_push),
		.wdata (word),
		.pop   (pop),
		.rdata (head),
		.empty (empty),
		.full  (full)
	);

	// refill the output register when it is free or is being emptied this cycle
	assign pop = !empty && (!blk_valid || blk_take);

	// Fibonacci LFSR run 64 times, the first keystream bit covers data bit 63
	always_comb
	begin : scramble
		logic key;
		lfsr_next = lfsr;
		for (int i = 63; i >= 0; i--)
		begin
			key         = lfsr_next[57] ^ lfsr_next[38]; // taps for x^58 and x^39
			scr_data[i] = head.data[i] ^ key;
			lfsr_next   = {lfsr_next[56:0], key};
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lfsr      <= SEED;
			blk_valid <= 1'b0;
		end
		else if (pop)
		begin
			lfsr      <= lfsr_next; // only advances when a word is really sent
			blk_valid <= 1'b1;
		end
		else if (blk_take)
			blk_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			blk.sync <= head.ctrl ? ilk_word_pkg::SYNC_CTRL : ilk_word_pkg::SYNC_DATA;
			blk.data <= scr_data;
		end
	end

endmodule

// File: rtl/ilk_lane_bundler.sv
// ====================================================================
// lane bundler: gathers one block from every lane and hands the row
// out over a four phase req/ack handshake
// ====================================================================

`timescale 1ns/1ps
`include "ilk_tx_settings.svh"

module ilk_lane_bundler (
	input  logic                   clk,
	input  logic                   rst,
	input  ilk_bus_pkg::out_row_t  blk,
	input  logic [`ILK_LANES-1:0]  blk_valid,
	output logic                   blk_take,
	output ilk_bus_pkg::out_row_t  out_row,
	output logic                   out_req,
	input  logic                   out_ack
);

	typedef enum logic [1:0] {
		B_COLLECT, // waiting until every lane holds a block
		B_REQ,     // row presented, req high until ack arrives
		B_DROP     // req released, waiting for ack to fall
	} state_t;

	state_t state;

	// take from all lanes at once so the lanes never drift apart
	assign blk_take = (state == B_COLLECT) && (&blk_valid);
	assign out_req  = (state == B_REQ);

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= B_COLLECT;
		else
		begin
			case (state)
				B_COLLECT:
					if (blk_take)
						state <= B_REQ; // req rises the cycle after the take
				B_REQ:
					if (out_ack)
						state <= B_DROP;
				default:
					if (!out_ack)
						state <= B_COLLECT; // handshake fully closed
			endcase
		end
	end

	// the row is held here for the whole handshake
	always_ff @(posedge clk)
	begin
		if (blk_take)
			out_row <= blk;
	end

endmodule

// File: rtl/ilk_tx_top.sv
// ====================================================================
// transmit path top level: striper, one transmitter per lane
// and the output bundler
// ====================================================================

`timescale 1ns/1ps
`include "ilk_tx_settings.svh"

module ilk_tx_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_req,
	input  ilk_bus_pkg::tx_beat_t in_beat,
	output logic                  in_ack,
	output logic                  out_req,
	input  logic                  out_ack,
	output ilk_bus_pkg::out_row_t out_row
);

	ilk_bus_pkg::lane_row_t row;       // same row goes to every lane, each picks its word
	logic                   row_push;
	logic [`ILK_LANES-1:0]  lane_full;
	ilk_bus_pkg::out_row_t  blk;
	logic [`ILK_LANES-1:0]  blk_valid;
	logic                   blk_take;

	ilk_tx_striper i_striper (
		.clk       (clk),
		.rst       (rst),
		.in_req    (in_req),
		.in_beat   (in_beat),
		.in_ack    (in_ack),
		.lane_full (lane_full),
		.row       (row),
		.row_push  (row_push)
	);

	for (genvar i = 0; i < `ILK_LANES; i++)
	begin : g_lane
		// each lane starts its scrambler from a different point
		ilk_lane_tx #(
			.SEED (58'(`ILK_SCRAMBLER_SEED + i * `ILK_SCRAMBLER_STEP))
		) i_lane_tx (
			.clk       (clk),
			.rst       (rst),
			.word      (row[i]),
			.word_push (row_push),
			.full      (lane_full[i]),
			.blk       (blk[i]),
			.blk_valid (blk_valid[i]),
			.blk_take  (blk_take)
		);
	end

	ilk_lane_bundler i_bundler (
		.clk       (clk),
		.rst       (rst),
		.blk       (blk),
		.blk_valid (blk_valid),
		.blk_take  (blk_take),
		.out_row   (out_row),
		.out_req   (out_req),
		.out_ack   (out_ack)
	);

endmodule

// File: test/ilk_tx_asserts.sv
// ======================================================================
// concurrent handshake assertions for the transmit path top level,
// attached to every instance of the top level by bind
// ======================================================================

`timescale 1ns/1ps

module ilk_tx_asserts (
	input logic                  clk,
	input logic                  rst,
	input logic                  in_req,
	input logic                  in_ack,
	input logic                  out_req,
	input logic                  out_ack,
	input ilk_bus_pkg::out_row_t out_row
);

	// once raised, the output request waits for the sink to answer
	req_held: assert property (@(posedge clk) disable iff (rst)
		out_req && !out_ack |=> out_req)
		else $error("out_req dropped before out_ack arrived");

	// the row under an open request must not move
	row_stable: assert property (@(posedge clk) disable iff (rst)
		out_req && $past(out_req) |-> $stable(out_row))
		else $error("out_row changed while out_req was high");

	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(in_ack) |-> in_req) // the striper answers only a live request
		else $error("in_ack rose while in_req was low");

endmodule

bind ilk_tx_top ilk_tx_asserts i_asserts (
	.clk     (clk),
	.rst     (rst),
	.in_req  (in_req),
	.in_ack  (in_ack),
	.out_req (out_req),
	.out_ack (out_ack),
	.out_row (out_row)
);

// File: test/ilk_tx_tb.sv
// ======================================================================
// testbench for the lane transmit path: beat table applied in a loop,
// LFSR payloads, row and scrambler reference model, both handshakes
// ======================================================================

`timescale 1ns/1ps
`include "ilk_tx_settings.svh"

module ilk_tx_tb;

	localparam int WAIT_LIMIT = 2000; // longest single wait in cycles
	localparam int N_BEATS    = 8;

	typedef struct packed {
		logic [2:0] count;
		logic       sop;
		logic       eop;
		logic [7:0] chan;
		logic [2:0] eop_bytes;
		logic [3:0] ack_delay; // row r takes its out_ack delay from line r mod 8
	} stim_t;

	logic                   clk = 1'b0;
	logic                   rst;
	logic                   in_req;
	ilk_bus_pkg::tx_beat_t  in_beat;
	logic                   in_ack;
	logic                   out_req;
	logic                   out_ack;
	ilk_bus_pkg::out_row_t  out_row;
	ilk_bus_pkg::tx_beat_t  beats [N_BEATS];
	ilk_bus_pkg::lane_row_t exp_rows [$]; // plain rows, scrambled only when compared
	logic [31:0]            lfsr_state = 32'h61e9d771;
	logic [57:0]            scr_state [`ILK_LANES]; // model scrambler, one per lane
	int                     errors = 0;
	int                     timeouts = 0;

	// count, sop, eop, channel, eop bytes, out_ack delay
	stim_t stim [N_BEATS] = '{
		'{3'd4, 1'b1, 1'b0, 8'h05, 3'd0, 4'd0},
		'{3'd4, 1'b0, 1'b0, 8'h05, 3'd0, 4'd1},
		'{3'd2, 1'b0, 1'b1, 8'h05, 3'd3, 4'd0},
		'{3'd4, 1'b1, 1'b1, 8'h2a, 3'd5, 4'd6},
		'{3'd1, 1'b1, 1'b1, 8'hc3, 3'd1, 4'd0},
		'{3'd3, 1'b1, 1'b0, 8'h7e, 3'd0, 4'd9},
		'{3'd4, 1'b0, 1'b0, 8'h7e, 3'd0, 4'd12},
		'{3'd4, 1'b0, 1'b1, 8'h7e, 3'd0, 4'd2}
	};

	ilk_tx_top i_ilk_tx_top (.*);

	always #2 clk = ~clk;

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit handed out
	function automatic logic [63:0] rand_word();
		logic [63:0] w;
		logic        fb;
		for (int i = 63; i >= 0; i--)
		begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			w[i]       = fb;
		end
		return w;
	endfunction

	// control flag, then type, channel, byte count and zero padding from the top
	function automatic ilk_word_pkg::lane_word_t ctrl_word(logic [1:0] kind,
		logic [7:0] chan, logic [2:0] bytes);
		return {1'b1, kind, chan, bytes, 51'd0};
	endfunction

	// optional burst row, data row with idle fill, optional eop row
	function automatic void expect_beat(ilk_bus_pkg::tx_beat_t b);
		ilk_bus_pkg::lane_row_t idle;
		ilk_bus_pkg::lane_row_t r;
		for (int k = 0; k < `ILK_LANES; k++)
			idle[k] = ctrl_word(ilk_word_pkg::CTRL_IDLE, 8'd0, 3'd0);
		r    = idle;
		r[0] = ctrl_word(ilk_word_pkg::CTRL_BURST, b.chan, 3'd0);
		if (b.sop)
			exp_rows.push_back(r);
		r = idle;
		for (int k = 0; k < int'(b.count); k++)
			r[k] = {1'b0, b.words[k]}; // word k belongs to lane k
		exp_rows.push_back(r);
		r    = idle;
		r[0] = ctrl_word(ilk_word_pkg::CTRL_EOP, b.chan, b.eop_bytes);
		if (b.eop)
			exp_rows.push_back(r);
	endfunction

	// x^58 + x^39 + 1, 64 steps per word, first key bit covers bit 63
	function automatic logic [63:0] scramble(int lane, logic [63:0] d);
		logic [57:0] s;
		logic [63:0] o;
		logic        key;
		s = scr_state[lane];
		for (int i = 63; i >= 0; i--)
		begin
			key  = s[57] ^ s[38];
			o[i] = d[i] ^ key;
			s    = {s[56:0], key};
		end
		scr_state[lane] = s; // state carries over to the next word of this lane
		return o;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	// sel 0 watches in_ack, sel 1 watches out_req, sampled at each rising edge
	task automatic wait_level(input logic sel, input logic level, input string what);
		int n;
		n = 0;
		@(posedge clk);
		while ((sel ? out_req : in_ack) !== level && n < WAIT_LIMIT)
		begin
			n++;
			@(posedge clk);
		end
		if ((sel ? out_req : in_ack) !== level)
		begin
			timeouts++;
			$display("timeout: %s", what);
			finish_run();
		end
	endtask

	task automatic send_beat(input int idx);
		in_beat <= beats[idx];
		in_req  <= 1'b1;
		wait_level(1'b0, 1'b1, $sformatf("in_ack never rose for beat %0d", idx));
		in_req <= 1'b0; // ack seen, release the request and keep the beat
		wait_level(1'b0, 1'b0, $sformatf("in_ack never fell for beat %0d", idx));
	endtask

	// one output row, compared lane by lane, then the handshake is closed
	task automatic take_row(input int r);
		ilk_bus_pkg::lane_row_t exp;
		logic [65:0]            want;
		exp = exp_rows.pop_front();
		wait_level(1'b1, 1'b1, $sformatf("out_req never rose for row %0d", r));
		for (int k = 0; k < `ILK_LANES; k++)
		begin
			want = {(exp[k].ctrl ? 2'b10 : 2'b01), scramble(k, exp[k].data)};
			check_value($sformatf("out_row[%0d] of row %0d", k, r), 128'(out_row[k]),
				128'(want));
		end
		repeat (stim[r % N_BEATS].ack_delay)
			@(posedge clk);
		out_ack <= 1'b1;
		wait_level(1'b1, 1'b0, $sformatf("out_req never fell for row %0d", r));
		out_ack <= 1'b0;
	endtask

	initial
	begin
		int   n_rows;
		logic extra;
		rst     = 1'b1;
		in_req  = 1'b0;
		in_beat = '0;
		out_ack = 1'b0;
		for (int i = 0; i < `ILK_LANES; i++)
			scr_state[i] = 58'(`ILK_SCRAMBLER_SEED + 58'(i) * `ILK_SCRAMBLER_STEP);
		for (int i = 0; i < N_BEATS; i++)
		begin
			beats[i] = {rand_word(), rand_word(), rand_word(), rand_word(), stim[i].count,
				stim[i].chan, stim[i].sop, stim[i].eop, stim[i].eop_bytes};
			expect_beat(beats[i]);
		end
		n_rows = exp_rows.size();
		// registers settle on the first edge, both handshakes stay quiet after that
		for (int c = 0; c < 16; c++)
		begin
			@(posedge clk);
			if (c > 0)
			begin
				check_value("in_ack", 128'(in_ack), 128'(1'b0));
				check_value("out_req", 128'(out_req), 128'(1'b0));
			end
		end
		rst <= 1'b0;
		@(posedge clk);
		check_value("in_ack", 128'(in_ack), 128'(1'b0));
		check_value("out_req", 128'(out_req), 128'(1'b0));
		fork
			for (int i = 0; i < N_BEATS; i++)
				send_beat(i);
			for (int r = 0; r < n_rows; r++)
				take_row(r);
		join
		extra = 1'b0;
		repeat (40)
		begin
			@(posedge clk);
			extra = extra | out_req; // any further request would be a duplicate row
		end
		check_value("out_req after last row", 128'(extra), 128'(1'b0));
		finish_run();
	end

endmodule

// File: ilk_tx.f
+incdir+rtl
rtl/ilk_word_pkg.sv
rtl/ilk_bus_pkg.sv
rtl/ilk_fifo.sv
rtl/ilk_tx_striper.sv
rtl/ilk_lane_tx.sv
rtl/ilk_lane_bundler.sv
rtl/ilk_tx_top.sv
test/ilk_tx_asserts.sv
test/ilk_tx_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = ilk_tx_tb
FILELIST  = ilk_tx.f
LOG       = sim.log

.PHONY: sim clean

# build, run, then let the pass line in the log decide the exit status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -x -e "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
